// ==== compile.f ====
source/cub_arch_pkg.sv
source/cub_isa_pkg.sv
source/cub_instr_decoder.sv
source/cub_operand_fetch.sv
source/cub_fu_issue_lane.sv
source/cub_wb_tag_fifo.sv
source/cub_id_stage.sv
dv/cub_id_props.sv
dv/cub_id_checker.sv
dv/tb_cub_id_stage.sv

// ==== dv/cub_id_checker.sv ====
// testbench checker: register file and tag queue model, lane output prediction, error counts
`default_nettype none
`timescale 1ns/10ps

module cub_id_checker #(
    parameter int TAG_DEPTH = 4
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  cub_arch_pkg::data_t                              instr_i,
    input  logic                                             instr_valid_i,
    input  logic                                             cflow_mode_i,
    input  cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   crbr_data_i,
    input  logic [cub_arch_pkg::NUM_FU-1:0]                  crbr_valid_i,
    input  logic                                             wb_we_i,
    input  cub_arch_pkg::rf_addr_t                           wb_waddr_i,
    input  cub_arch_pkg::data_t                              wb_wdata_i,
    input  logic                                             ex_valid_i,
    input  cub_arch_pkg::data_t                              ex_wdata_i,
    input  logic [cub_arch_pkg::NUM_FU-1:0]                  fu_en_i,
    input  cub_isa_pkg::fu_op_t [cub_arch_pkg::NUM_FU-1:0]   fu_op_i,
    input  cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   fu_operand_a_i,
    input  cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   fu_operand_b_i,
    input  logic                                             illegal_insn_i,
    input  logic                                             tag_full_i,
    input  logic                                             done_i,
    output int                                               error_count_o
);

    import cub_arch_pkg::*;
    import cub_isa_pkg::*;

    data_t    rf_model [2 ** RF_ADDR_W];
    rf_addr_t tag_q [$];
    logic     exp_en [NUM_FU];
    fu_op_t   exp_op [NUM_FU];
    data_t    exp_a [NUM_FU];
    data_t    exp_b [NUM_FU];
    logic     exp_illegal;
    int       lane_errors = 0;
    int       flag_errors = 0;
    int       tag_errors = 0;
    int       cycles = 0;

    assign error_count_o = lane_errors + flag_errors + tag_errors;

    // r0 reads zero, then ex bypass, then wb bypass, then stored value
    function automatic data_t model_read(input rf_addr_t addr, input logic ex_we,
                                         input rf_addr_t ex_addr);
        if (addr == '0) return '0;
        if (ex_we && (ex_addr == addr)) return ex_wdata_i;
        if (wb_we_i && (wb_waddr_i == addr)) return wb_wdata_i;
        return rf_model[addr];
    endfunction

    task automatic compare_word(input string name, input int idx, input data_t got,
                                input data_t exp);
        if (got !== exp) begin
            $display("FAILED %s[%0d]: got %h, expected %h", name, idx, got, exp);
            lane_errors++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 2 ** RF_ADDR_W; i++) begin
            rf_model[i] = '0;
        end
        tag_q.delete();
        for (int g = 0; g < NUM_FU; g++) begin
            exp_en[g] = 1'b0;
            exp_op[g] = '0;
            exp_a[g]  = '0;
            exp_b[g]  = '0;
        end
        exp_illegal = 1'b0;
    endtask

    // ========================================================================
    // compare, then predict what the next edge captures
    // ========================================================================
    task automatic compare_outputs();
        cycles++;
        for (int g = 0; g < NUM_FU; g++) begin
            compare_word("fu_en_o", g, data_t'(fu_en_i[g]), data_t'(exp_en[g]));
            compare_word("fu_op_o", g, data_t'(fu_op_i[g]), data_t'(exp_op[g]));
            compare_word("fu_operand_a_o", g, fu_operand_a_i[g], exp_a[g]);
            compare_word("fu_operand_b_o", g, fu_operand_b_i[g], exp_b[g]);
        end
        if (illegal_insn_i !== exp_illegal) begin
            $display("FAILED illegal_insn_o: got %h, expected %h", illegal_insn_i, exp_illegal);
            flag_errors++;
        end
        if (tag_full_i !== (tag_q.size() == TAG_DEPTH)) begin
            $display("FAILED tag_full_o: got %h, expected %h", tag_full_i,
                     tag_q.size() == TAG_DEPTH);
            tag_errors++;
        end
    endtask

    task automatic predict_next();
        logic     ex_we;
        rf_addr_t ex_addr;
        logic     legal;
        logic     use_imm;
        int       lane;
        // ex result belongs to the oldest outstanding tag
        ex_we       = ex_valid_i && (tag_q.size() != 0);
        ex_addr     = ex_we ? tag_q[0] : '0;
        exp_illegal = 1'b0;
        legal       = 1'b1;
        use_imm     = 1'b0;
        lane        = FU_ALU;
        // dataflow: channel valid straight to enable, only operand a moves
        for (int g = 0; g < NUM_FU; g++) begin
            exp_en[g] = cflow_mode_i && crbr_valid_i[g];
            if (cflow_mode_i && crbr_valid_i[g]) begin
                exp_a[g] = crbr_data_i[g];
            end
        end
        if (!cflow_mode_i && instr_valid_i) begin
            case (instr_i[OPC_MSB:OPC_LSB])
                OPC_ALU_RR:  lane = FU_ALU;
                OPC_ALU_RI: begin
                    lane    = FU_ALU;
                    use_imm = 1'b1;
                end
                OPC_MUL_RR:  lane = FU_MULT;
                OPC_ACT_R:   lane = FU_ACTI;
                OPC_POOL_RR: lane = FU_POOL;
                default:     legal = 1'b0;
            endcase
            if (legal) begin
                if (tag_q.size() >= TAG_DEPTH) begin
                    $display("stimulus issued an instruction while every tag was in use");
                    tag_errors++;
                end
                exp_en[lane] = 1'b1;
                exp_op[lane] = instr_i[FUNC_MSB:FUNC_LSB];
                exp_a[lane]  = model_read(instr_i[RS1_MSB:RS1_LSB], ex_we, ex_addr);
                exp_b[lane]  = use_imm ? {{20{instr_i[31]}}, instr_i[31:20]}
                                       : model_read(instr_i[RS2_MSB:RS2_LSB], ex_we, ex_addr);
                tag_q.push_back(instr_i[RD_MSB:RD_LSB]);
            end else begin
                exp_illegal = 1'b1;
            end
        end
        // wb lands first so a same-register ex write wins
        if (wb_we_i && (wb_waddr_i != '0)) begin
            rf_model[wb_waddr_i] = wb_wdata_i;
        end
        if (ex_we && (ex_addr != '0)) begin
            rf_model[ex_addr] = ex_wdata_i;
        end
        if (ex_we) begin
            void'(tag_q.pop_front());
        end
    endtask

    // inputs and registered outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            compare_outputs();
            predict_next();
        end
    end

    always @(posedge done_i) begin
        $display("checker: %0d cycles compared, %0d errors (lanes %0d, illegal flag %0d, tags %0d)",
                 cycles, error_count_o, lane_errors, flag_errors, tag_errors);
    end

endmodule

`default_nettype wire

// ==== dv/cub_id_props.sv ====
// bound assertions on lane enable shape, the illegal flag pulse and tag pushes into a full FIFO
`default_nettype none
`timescale 1ns/10ps

module cub_id_props (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cflow_mode_i,
    input  logic                              issue_i,
    input  logic                              illegal_i,
    input  logic [cub_arch_pkg::NUM_FU-1:0]   fu_en_i,
    input  logic                              illegal_insn_i,
    input  logic                              tag_full_i
);

    // an issued instruction lights exactly one lane
    a_issue_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        issue_i |=> $onehot(fu_en_i))
        else $error("issue did not enable exactly one lane");

    // normal mode never enables two lanes at once
    a_normal_onehot0 : assert property (@(posedge clk) disable iff (!rst_n)
        !cflow_mode_i |=> $onehot0(fu_en_i))
        else $error("more than one lane enabled in normal mode");

    // illegal opcode flagged next cycle with nothing issued
    a_illegal_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        illegal_i |=> (illegal_insn_i && (fu_en_i == '0)))
        else $error("illegal opcode not flagged or lane enabled");

    // every issue takes a tag slot
    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
        tag_full_i |-> !issue_i)
        else $error("instruction issued while the tag FIFO was full");

endmodule

bind cub_id_stage cub_id_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .cflow_mode_i   (cflow_mode_i),
    .issue_i        (issue),
    .illegal_i      (illegal),
    .fu_en_i        (fu_en_o),
    .illegal_insn_i (illegal_insn_o),
    .tag_full_i     (tag_full_o)
);

`default_nettype wire

// ==== dv/tb_cub_id_stage.sv ====
// decode stage testbench: clock, reset, seeded random stimulus, timeout, DUT and checker
`default_nettype none
`timescale 1ns/10ps

module tb_cub_id_stage;

    import cub_arch_pkg::*;
    import cub_isa_pkg::*;

    localparam int TAG_DEPTH      = 4;
    localparam int NUM_OPS        = 2000;
    localparam int RESET_CYCLES   = 4;
    // one cycle per op, the rest covers reset and drain
    localparam int TIMEOUT_CYCLES = NUM_OPS + 100;

    logic                   clk;
    logic                   rst_n;
    data_t                  instr_i;
    logic                   instr_valid_i;
    logic                   cflow_mode_i;
    data_t [NUM_FU-1:0]     crbr_data_i;
    logic [NUM_FU-1:0]      crbr_valid_i;
    logic                   wb_we_i;
    rf_addr_t               wb_waddr_i;
    data_t                  wb_wdata_i;
    logic                   ex_valid_i;
    data_t                  ex_wdata_i;
    logic [NUM_FU-1:0]      fu_en_o;
    fu_op_t [NUM_FU-1:0]    fu_op_o;
    data_t [NUM_FU-1:0]     fu_operand_a_o;
    data_t [NUM_FU-1:0]     fu_operand_b_o;
    logic                   illegal_insn_o;
    logic                   tag_full_o;

    integer seed;
    int     tags_out;
    int     cycle_cnt;
    int     error_count;
    logic   dataflow;
    logic   done;

    cub_id_stage #(.TAG_DEPTH(TAG_DEPTH)) uut (.*);

    cub_id_checker #(.TAG_DEPTH(TAG_DEPTH)) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_i        (instr_i),
        .instr_valid_i  (instr_valid_i),
        .cflow_mode_i   (cflow_mode_i),
        .crbr_data_i    (crbr_data_i),
        .crbr_valid_i   (crbr_valid_i),
        .wb_we_i        (wb_we_i),
        .wb_waddr_i     (wb_waddr_i),
        .wb_wdata_i     (wb_wdata_i),
        .ex_valid_i     (ex_valid_i),
        .ex_wdata_i     (ex_wdata_i),
        .fu_en_i        (fu_en_o),
        .fu_op_i        (fu_op_o),
        .fu_operand_a_i (fu_operand_a_o),
        .fu_operand_b_i (fu_operand_b_o),
        .illegal_insn_i (illegal_insn_o),
        .tag_full_i     (tag_full_o),
        .done_i         (done),
        .error_count_o  (error_count)
    );

    function automatic logic opcode_known(input logic [6:0] opc);
        return opc inside {OPC_ALU_RR, OPC_ALU_RI, OPC_MUL_RR, OPC_ACT_R, OPC_POOL_RR};
    endfunction

    // ========================================================================
    // one random cycle of stimulus
    // ========================================================================
    task automatic drive_cycle();
        logic [31:0] rnd;
        logic [6:0]  opc;
        data_t       word;
        logic        valid;
        logic        legal;
        logic        pop;
        rnd  = $random(seed);
        word = $random(seed);
        // rare flips, long runs in each mode
        if (rnd[31:26] == '0) begin
            dataflow = !dataflow;
        end
        case (rnd[11:9])
            3'd0, 3'd6: opc = OPC_ALU_RR;
            3'd1, 3'd2: opc = OPC_ALU_RI;
            3'd3:       opc = OPC_MUL_RR;
            3'd4:       opc = OPC_ACT_R;
            3'd5:       opc = OPC_POOL_RR;
            default: begin
                opc = word[6:0];
                while (opcode_known(opc)) begin
                    opc = opc + 7'd1;
                end
            end
        endcase
        legal = opcode_known(opc);
        word[OPC_MSB:OPC_LSB] = opc;
        // r0..r7 only, so ex and wb hazards come up often
        word[RS1_MSB:RS1_LSB] = {2'b00, rnd[2:0]};
        word[RD_MSB:RD_LSB]   = {2'b00, rnd[8:6]};
        if (opc != OPC_ALU_RI) begin
            word[RS2_MSB:RS2_LSB] = {2'b00, rnd[5:3]};
        end
        valid = (rnd[20:18] != 3'd0);
        // count tracks tag_full_o after this edge
        if (legal && !dataflow && (tags_out >= TAG_DEPTH)) begin
            valid = 1'b0;
        end
        pop      = !rnd[17] && (tags_out > 0);
        tags_out = tags_out + int'(valid && legal && !dataflow) - int'(pop);

        cflow_mode_i  <= dataflow;
        instr_i       <= word;
        instr_valid_i <= valid;
        wb_we_i       <= rnd[15];
        wb_waddr_i    <= {2'b00, rnd[14:12]};
        wb_wdata_i    <= $random(seed);
        ex_valid_i    <= pop;
        ex_wdata_i    <= $random(seed);
        crbr_valid_i  <= rnd[24:21];
        for (int g = 0; g < NUM_FU; g++) begin
            crbr_data_i[g] <= $random(seed);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: stimulus still running after %0d cycles", cycle_cnt);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed          = 32'hac4f_200e;
        rst_n         = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        cflow_mode_i  = 1'b0;
        crbr_data_i   = '0;
        crbr_valid_i  = '0;
        wb_we_i       = 1'b0;
        wb_waddr_i    = '0;
        wb_wdata_i    = '0;
        ex_valid_i    = 1'b0;
        ex_wdata_i    = '0;
        dataflow      = 1'b0;
        tags_out      = 0;
        done          = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            @(posedge clk);
            drive_cycle();
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
        ex_valid_i    <= 1'b0;
        wb_we_i       <= 1'b0;
        crbr_valid_i  <= '0;
        repeat (2) @(posedge clk);
        done = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cub_id_stage \
    -f compile.f -o sim_cub_id > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_cub_id > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation PASSED"

// ==== source/cub_arch_pkg.sv ====
// datapath widths, operand and register address types, lane count, functional-unit enum
`default_nettype none

package cub_arch_pkg;

    // ========================================================================
    // datapath sizing
    // ========================================================================
    localparam int DATA_W    = 32;
    localparam int RF_ADDR_W = 5;

    // lanes and crossbar channels share one index space
    localparam int NUM_FU    = 4;

    // one operand word
    typedef logic [DATA_W-1:0]    data_t;

    // one register file address
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // unit encoding doubles as lane index and crossbar channel index
    typedef enum logic [1:0] {
        FU_MULT = 2'd0,
        FU_ALU  = 2'd1,
        FU_ACTI = 2'd2,
        FU_POOL = 2'd3
    } fu_e;

endpackage

`default_nettype wire

// ==== source/cub_fu_issue_lane.sv ====
// functional-unit issue lane: enable, operator and operand registers, normal or dataflow load
`default_nettype none
`timescale 1ns/10ps

module cub_fu_issue_lane (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_i,
    input  logic                 cflow_mode_i,
    input  cub_isa_pkg::fu_op_t  op_i,
    input  cub_arch_pkg::data_t  operand_a_i,
    input  cub_arch_pkg::data_t  operand_b_i,
    input  logic                 crbr_valid_i,
    input  cub_arch_pkg::data_t  crbr_data_i,
    output logic                 en_o,
    output cub_isa_pkg::fu_op_t  op_o,
    output cub_arch_pkg::data_t  operand_a_o,
    output cub_arch_pkg::data_t  operand_b_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_o        <= 1'b0;
            op_o        <= '0;
            operand_a_o <= '0;
            operand_b_o <= '0;
        end else if (cflow_mode_i) begin
            // dataflow: channel valid drives the enable directly
            en_o <= crbr_valid_i;
            // only operand a streams in, b and operator keep last setup
            if (crbr_valid_i) begin
                operand_a_o <= crbr_data_i;
            end
        end else begin
            // single-cycle enable per issued instruction
            en_o <= issue_i;
            if (issue_i) begin
                op_o        <= op_i;
                operand_a_o <= operand_a_i;
                operand_b_o <= operand_b_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cub_id_stage.sv ====
// decode stage top: decoder, operand fetch, four issue lanes, write-back tag FIFO
`default_nettype none
`timescale 1ns/10ps

module cub_id_stage #(
    parameter int TAG_DEPTH = 4
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  cub_arch_pkg::data_t                              instr_i,
    input  logic                                             instr_valid_i,
    input  logic                                             cflow_mode_i,
    input  cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   crbr_data_i,
    input  logic [cub_arch_pkg::NUM_FU-1:0]                  crbr_valid_i,
    input  logic                                             wb_we_i,
    input  cub_arch_pkg::rf_addr_t                           wb_waddr_i,
    input  cub_arch_pkg::data_t                              wb_wdata_i,
    input  logic                                             ex_valid_i,
    input  cub_arch_pkg::data_t                              ex_wdata_i,
    output logic [cub_arch_pkg::NUM_FU-1:0]                  fu_en_o,
    output cub_isa_pkg::fu_op_t [cub_arch_pkg::NUM_FU-1:0]   fu_op_o,
    output cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   fu_operand_a_o,
    output cub_arch_pkg::data_t [cub_arch_pkg::NUM_FU-1:0]   fu_operand_b_o,
    output logic                                             illegal_insn_o,
    output logic                                             tag_full_o
);

    import cub_arch_pkg::*;
    import cub_isa_pkg::*;

    fu_e      fu_sel;
    fu_op_t   fu_op;
    logic     issue;
    logic     use_imm;
    logic     illegal;
    data_t    operand_a;
    data_t    operand_b;
    rf_addr_t rd;
    rf_addr_t tag_head;

    // ========================================================================
    // decode and operand fetch
    // ========================================================================
    cub_instr_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .cflow_mode_i  (cflow_mode_i),
        .fu_sel_o      (fu_sel),
        .fu_op_o       (fu_op),
        .issue_o       (issue),
        .use_imm_o     (use_imm),
        .illegal_o     (illegal)
    );

    // ex result lands on the oldest tag, pop and write share ex_valid_i
    cub_operand_fetch u_operand_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_i     (instr_i),
        .use_imm_i   (use_imm),
        .wb_we_i     (wb_we_i),
        .wb_waddr_i  (wb_waddr_i),
        .wb_wdata_i  (wb_wdata_i),
        .ex_we_i     (ex_valid_i),
        .ex_waddr_i  (tag_head),
        .ex_wdata_i  (ex_wdata_i),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b)
    );

    // ========================================================================
    // issue lanes, indexed by fu_e
    // ========================================================================
    for (genvar g = 0; g < NUM_FU; g++) begin : g_lane
        logic lane_issue;

        assign lane_issue = issue && (fu_sel == fu_e'(g));

        cub_fu_issue_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue_i      (lane_issue),
            .cflow_mode_i (cflow_mode_i),
            .op_i         (fu_op),
            .operand_a_i  (operand_a),
            .operand_b_i  (operand_b),
            .crbr_valid_i (crbr_valid_i[g]),
            .crbr_data_i  (crbr_data_i[g]),
            .en_o         (fu_en_o[g]),
            .op_o         (fu_op_o[g]),
            .operand_a_o  (fu_operand_a_o[g]),
            .operand_b_o  (fu_operand_b_o[g])
        );
    end

    // destination of every issued result, in issue order
    assign rd = instr_i[RD_MSB:RD_LSB];

    cub_wb_tag_fifo #(
        .TAG_DEPTH (TAG_DEPTH)
    ) u_tag_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .push_i (issue),
        .rd_i   (rd),
        .pop_i  (ex_valid_i),
        .head_o (tag_head),
        .full_o (tag_full_o)
    );

    // illegal flag lines up with the lane outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            illegal_insn_o <= 1'b0;
        end else begin
            illegal_insn_o <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== source/cub_instr_decoder.sv ====
// instruction decoder: unit select, operand b source, issue strobe and illegal flag
`default_nettype none
`timescale 1ns/10ps

module cub_instr_decoder (
    input  cub_arch_pkg::data_t  instr_i,
    input  logic                 instr_valid_i,
    input  logic                 cflow_mode_i,
    output cub_arch_pkg::fu_e    fu_sel_o,
    output cub_isa_pkg::fu_op_t  fu_op_o,
    output logic                 issue_o,
    output logic                 use_imm_o,
    output logic                 illegal_o
);

    import cub_arch_pkg::*;
    import cub_isa_pkg::*;

    opcode_e opcode;
    logic    legal;
    logic    active;

    assign opcode = opcode_e'(instr_i[OPC_MSB:OPC_LSB]);

    // ========================================================================
    // opcode match
    // ========================================================================
    always_comb begin
        // defaults for an unknown opcode
        legal     = 1'b1;
        fu_sel_o  = FU_ALU;
        use_imm_o = 1'b0;
        case (opcode)
            OPC_ALU_RR: begin
                fu_sel_o = FU_ALU;
            end
            OPC_ALU_RI: begin
                // operand b from the sign-extended immediate
                fu_sel_o  = FU_ALU;
                use_imm_o = 1'b1;
            end
            OPC_MUL_RR: begin
                fu_sel_o = FU_MULT;
            end
            OPC_ACT_R: begin
                // single source, rs2 field ignored by the unit
                fu_sel_o = FU_ACTI;
            end
            OPC_POOL_RR: begin
                fu_sel_o = FU_POOL;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // operator field passes through unchanged
    assign fu_op_o = instr_i[FUNC_MSB:FUNC_LSB];

    // dataflow mode ignores the instruction stream entirely
    assign active = instr_valid_i && !cflow_mode_i;

    // one strobe shared by the lane select and the tag push
    assign issue_o   = active && legal;
    assign illegal_o = active && !legal;

endmodule

`default_nettype wire

// ==== source/cub_isa_pkg.sv ====
// opcode enum, instruction field positions, operator field type
`default_nettype none

package cub_isa_pkg;

    // ========================================================================
    // instruction fields
    // ========================================================================
    localparam int OPC_LSB  = 0;
    localparam int OPC_MSB  = 6;
    localparam int RD_LSB   = 7;
    localparam int RD_MSB   = 11;
    localparam int FUNC_LSB = 12;
    localparam int FUNC_MSB = 14;
    localparam int RS1_LSB  = 15;
    localparam int RS1_MSB  = 19;
    localparam int RS2_LSB  = 20;
    localparam int RS2_MSB  = 24;

    // i-type immediate, sign bit is the top instruction bit
    localparam int IMM_LSB  = 20;
    localparam int IMM_MSB  = 31;
    localparam int IMM_W    = IMM_MSB - IMM_LSB + 1;

    // major opcodes, one unit each
    typedef enum logic [6:0] {
        OPC_ALU_RR  = 7'b0110011,
        OPC_ALU_RI  = 7'b0010011,
        OPC_MUL_RR  = 7'b0111011,
        OPC_ACT_R   = 7'b0001011,
        OPC_POOL_RR = 7'b0101011
    } opcode_e;

    // unit operator, forwarded to the lane untouched
    typedef logic [FUNC_MSB-FUNC_LSB:0] fu_op_t;

endpackage

`default_nettype wire

// ==== source/cub_operand_fetch.sv ====
// operand fetch: two-write-port register file, source forwarding, immediate extension
`default_nettype none
`timescale 1ns/10ps

module cub_operand_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cub_arch_pkg::data_t     instr_i,
    input  logic                    use_imm_i,
    input  logic                    wb_we_i,
    input  cub_arch_pkg::rf_addr_t  wb_waddr_i,
    input  cub_arch_pkg::data_t     wb_wdata_i,
    input  logic                    ex_we_i,
    input  cub_arch_pkg::rf_addr_t  ex_waddr_i,
    input  cub_arch_pkg::data_t     ex_wdata_i,
    output cub_arch_pkg::data_t     operand_a_o,
    output cub_arch_pkg::data_t     operand_b_o
);

    import cub_arch_pkg::*;
    import cub_isa_pkg::*;

    localparam int RF_DEPTH = 2 ** RF_ADDR_W;

    data_t    rf_q [RF_DEPTH];
    rf_addr_t raddr_a;
    rf_addr_t raddr_b;
    data_t    fwd_a;
    data_t    fwd_b;
    data_t    imm_sext;

    // ex port beats wb port, then the stored value
    function automatic data_t forward(input rf_addr_t raddr, input data_t rf_value);
        data_t value;
        value = rf_value;
        if (raddr == '0) begin
            value = '0;
        end else if (ex_we_i && (ex_waddr_i == raddr)) begin
            value = ex_wdata_i;
        end else if (wb_we_i && (wb_waddr_i == raddr)) begin
            value = wb_wdata_i;
        end
        return value;
    endfunction

    // ========================================================================
    // register file
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            // r0 is hardwired, never written
            if (wb_we_i && (wb_waddr_i != '0)) begin
                rf_q[wb_waddr_i] <= wb_wdata_i;
            end
            // later assignment, so ex wins a same-address collision
            if (ex_we_i && (ex_waddr_i != '0)) begin
                rf_q[ex_waddr_i] <= ex_wdata_i;
            end
        end
    end

    // ========================================================================
    // source read and bypass
    // ========================================================================
    assign raddr_a = instr_i[RS1_MSB:RS1_LSB];
    assign raddr_b = instr_i[RS2_MSB:RS2_LSB];

    always_comb begin
        fwd_a = forward(raddr_a, rf_q[raddr_a]);
        fwd_b = forward(raddr_b, rf_q[raddr_b]);
    end

    // i-type immediate, sign-extended to the datapath
    assign imm_sext = {{(DATA_W - IMM_W){instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

    assign operand_a_o = fwd_a;
    assign operand_b_o = use_imm_i ? imm_sext : fwd_b;

endmodule

`default_nettype wire

// ==== source/cub_wb_tag_fifo.sv ====
// write-back tag FIFO: in-order destination addresses of outstanding unit results
`default_nettype none
`timescale 1ns/10ps

module cub_wb_tag_fifo #(
    parameter int TAG_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push_i,
    input  cub_arch_pkg::rf_addr_t  rd_i,
    input  logic                    pop_i,
    output cub_arch_pkg::rf_addr_t  head_o,
    output logic                    full_o
);

    import cub_arch_pkg::*;

    localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CNT_W = $clog2(TAG_DEPTH + 1);

    rf_addr_t           tag_mem [TAG_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    // wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // overflow and underflow guards
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && (count_q != '0);

    // tag storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            tag_mem[wr_ptr_q] <= rd_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // oldest outstanding destination
    assign head_o = tag_mem[rd_ptr_q];
    assign full_o = (count_q == CNT_W'(TAG_DEPTH));

endmodule

`default_nettype wire
